// File: Makefile
SIM = obj_dir/Vpcs_tx_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"

$(SIM): tb.f hdl/*.sv test/*.sv
	verilator --binary --assert -f tb.f --top-module pcs_tx_tb -o Vpcs_tx_tb

test: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf obj_dir

// File: hdl/pcs_pkg.sv
// 10GBASE-R transmit PCS constants and shared types.
// Widths and codes are fixed by the standard and are not parameters.
// Byte 0 of a CGMII word is bits 63 to 56.
package pcs_pkg;

	////////////////////////////////////////
	// widths
	localparam int DATA_WIDTH  = 64;
	localparam int CTRL_WIDTH  = 8;
	localparam int BLOCK_WIDTH = 66;

	////////////////////////////////////////
	// cgmii characters
	localparam logic [7:0] CGMII_START     = 8'hFB;
	localparam logic [7:0] CGMII_TERMINATE = 8'hFD;
	localparam logic [7:0] CGMII_IDLE      = 8'h07;
	localparam logic [7:0] CGMII_ERROR     = 8'hFE;
	localparam logic [7:0] CGMII_Q         = 8'h9C;
	localparam logic [7:0] CGMII_FSIG      = 8'h5C;

	// pcs control characters, 7 bits
	localparam logic [6:0] PCS_IDLE  = 7'h00;
	localparam logic [6:0] PCS_ERROR = 7'h1E;
	// ordered set codes, 4 bits
	localparam logic [3:0] PCS_O_Q    = 4'h0;
	localparam logic [3:0] PCS_O_FSIG = 4'hF;

	// sync headers
	localparam logic [1:0] SYNC_DATA = 2'b01;
	localparam logic [1:0] SYNC_CTRL = 2'b10;

	// block type field
	localparam logic [7:0] BTYPE_CTRL  = 8'h1E;
	localparam logic [7:0] BTYPE_START = 8'h78;
	localparam logic [7:0] BTYPE_ORDER = 8'h4B;
	localparam logic [7:0] BTYPE_T0    = 8'h87;
	localparam logic [7:0] BTYPE_T1    = 8'h99;
	localparam logic [7:0] BTYPE_T2    = 8'hAA;
	localparam logic [7:0] BTYPE_T3    = 8'hB4;
	localparam logic [7:0] BTYPE_T4    = 8'hCC;
	localparam logic [7:0] BTYPE_T5    = 8'hD2;
	localparam logic [7:0] BTYPE_T6    = 8'hE1;
	localparam logic [7:0] BTYPE_T7    = 8'hFF;

	////////////////////////////////////////
	// block class as seen by the tx fsm
	typedef enum logic [2:0] {CLASS_D, CLASS_S, CLASS_C, CLASS_T, CLASS_E} block_class_e;

	// one 66-bit block, read as payload or as type plus body
	typedef struct packed {logic [1:0] sync; logic [63:0] payload;} data_view_t;
	typedef struct packed {logic [1:0] sync; logic [7:0] btype; logic [55:0] body;} ctrl_view_t;

	typedef union packed {
		data_view_t data_view;
		ctrl_view_t ctrl_view;
	} coded_block_u;

endpackage

// File: hdl/pcs_scrambler.sv
// Self-synchronizing x^58 + x^39 + 1 scrambler over the 64 payload bits.
// Sync header passes through unscrambled.
// History advances only on valid blocks, so idle gaps do not disturb it.
module pcs_scrambler
	import pcs_pkg::*;
(
	input  logic         i_clock,
	input  logic         i_reset,
	input  coded_block_u i_block,
	input  logic         i_block_valid,
	output coded_block_u o_block,
	output logic         o_block_valid
);

	// 58 most recent scrambled bits, newest at bit 0
	logic [57:0]           scr_state;
	logic [57:0]           scr_next;
	logic [DATA_WIDTH-1:0] scr_payload;

	// serial unroll, bit 0 goes first
	always_comb
	begin
		scr_next = scr_state;
		for (int i = 0; i < DATA_WIDTH; i++)
		begin
			scr_payload[i] = i_block.data_view.payload[i] ^ scr_next[38] ^ scr_next[57];
			scr_next = {scr_next[56:0], scr_payload[i]};
		end
	end

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			scr_state     <= '1;
			o_block_valid <= 1'b0;
		end
		else
		begin
			o_block_valid <= i_block_valid;
			if (i_block_valid)
				scr_state <= scr_next;
		end
	end

	always_ff @(posedge i_clock)
	begin
		if (i_block_valid)
		begin
			o_block.data_view.sync    <= i_block.data_view.sync;
			o_block.data_view.payload <= scr_payload;
		end
	end

endmodule

// File: hdl/pcs_tx_encoder.sv
// CGMII to 64b/66b block encoder, unscrambled output.
// Two register stages: input latch, then the coded block with its class.
// Data and control are sampled only while i_enable is high.
// Unrecognized words become a control block of eight PCS error characters.
module pcs_tx_encoder
	import pcs_pkg::*;
(
	input  logic                  i_clock,
	input  logic                  i_reset,
	input  logic                  i_enable,
	input  logic [DATA_WIDTH-1:0] i_tx_data,
	input  logic [CTRL_WIDTH-1:0] i_tx_ctrl,
	output coded_block_u          o_block,
	output block_class_e          o_block_class,
	output logic                  o_block_valid
);

	// latched word
	logic [DATA_WIDTH-1:0] tx_data;
	logic [CTRL_WIDTH-1:0] tx_ctrl;
	logic                  tx_valid;
	logic [7:0]            byte0;
	// per byte idle or error, bytes 1 to 7
	logic [7:1]            char_ok;
	// mapped pcs chars of bytes 1 to 7, byte 1 on top
	logic [48:0]           pcs_tail;
	// terminate detection
	logic                  term_hit;
	logic [2:0]            term_n;
	logic [55:0]           term_body;
	logic [7:0]            term_btype;
	coded_block_u          next_block;
	block_class_e          next_class;

	////////////////////////////////////////
	// stage 1, input latch
	always_ff @(posedge i_clock)
	begin
		if (i_reset)
			tx_valid <= 1'b0;
		else
			tx_valid <= i_enable;
	end

	always_ff @(posedge i_clock)
	begin
		if (i_enable)
		begin
			tx_data <= i_tx_data;
			tx_ctrl <= i_tx_ctrl;
		end
	end

	assign byte0 = tx_data[DATA_WIDTH-1 -: 8];

	////////////////////////////////////////
	// character map, idle and error only
	always_comb
	begin
		for (int i = 1; i < 8; i++)
		begin
			char_ok[i] = (tx_data[DATA_WIDTH-1-8*i -: 8] == CGMII_IDLE) ||
				(tx_data[DATA_WIDTH-1-8*i -: 8] == CGMII_ERROR);
			// non idle maps to error too, only read when char_ok
			pcs_tail[7*(7-i) +: 7] = (tx_data[DATA_WIDTH-1-8*i -: 8] == CGMII_IDLE) ?
				PCS_IDLE : PCS_ERROR;
		end
	end

	// Tn: ctrl is FF >> n, byte n is /T/, every later byte idle or error
	always_comb
	begin
		term_hit = 1'b0;
		term_n   = 3'd0;
		for (int n = 0; n < 8; n++)
		begin
			if ((tx_ctrl == (8'hFF >> n)) &&
				(tx_data[DATA_WIDTH-1-8*n -: 8] == CGMII_TERMINATE) &&
				(((7'h7F << n) & ~char_ok) == 7'h00))
			begin
				term_hit = 1'b1;
				term_n   = n[2:0];
			end
		end
	end

	// n data bytes on top, zero fill, then the mapped tail
	always_comb
	begin
		term_body = (tx_data[DATA_WIDTH-1:8] & ~(56'hFF_FFFF_FFFF_FFFF >> (8 * term_n))) |
			{7'd0, pcs_tail & ((49'd1 << (7 * (7 - term_n))) - 49'd1)};
		case (term_n)
			3'd0: term_btype = BTYPE_T0;
			3'd1: term_btype = BTYPE_T1;
			3'd2: term_btype = BTYPE_T2;
			3'd3: term_btype = BTYPE_T3;
			3'd4: term_btype = BTYPE_T4;
			3'd5: term_btype = BTYPE_T5;
			3'd6: term_btype = BTYPE_T6;
			default: term_btype = BTYPE_T7;
		endcase
	end

	////////////////////////////////////////
	// classify and build the block
	always_comb
	begin
		// error control block unless a rule below matches
		next_block.ctrl_view.sync  = SYNC_CTRL;
		next_block.ctrl_view.btype = BTYPE_CTRL;
		next_block.ctrl_view.body  = {8{PCS_ERROR}};
		next_class = CLASS_E;
		if (tx_ctrl == 8'h00)
		begin
			next_block.data_view.sync    = SYNC_DATA;
			next_block.data_view.payload = tx_data;
			next_class = CLASS_D;
		end
		else if ((tx_ctrl == 8'h80) && (byte0 == CGMII_START))
		begin
			next_block.ctrl_view.btype = BTYPE_START;
			next_block.ctrl_view.body  = tx_data[55:0];
			next_class = CLASS_S;
		end
		else if ((tx_ctrl == 8'h80) && ((byte0 == CGMII_Q) || (byte0 == CGMII_FSIG)))
		begin
			// bytes 1 to 3 carried, O code, rest zero
			next_block.ctrl_view.btype = BTYPE_ORDER;
			next_block.ctrl_view.body  = {tx_data[55:32],
				(byte0 == CGMII_Q) ? PCS_O_Q : PCS_O_FSIG, 28'd0};
			next_class = CLASS_C;
		end
		else if ((tx_ctrl == 8'hFF) && (tx_data == {8{CGMII_IDLE}}))
		begin
			next_block.ctrl_view.body = {8{PCS_IDLE}};
			next_class = CLASS_C;
		end
		else if (term_hit)
		begin
			next_block.ctrl_view.btype = term_btype;
			next_block.ctrl_view.body  = term_body;
			next_class = CLASS_T;
		end
	end

	////////////////////////////////////////
	// stage 2, block register
	always_ff @(posedge i_clock)
	begin
		if (i_reset)
			o_block_valid <= 1'b0;
		else
			o_block_valid <= tx_valid;
	end

	always_ff @(posedge i_clock)
	begin
		if (tx_valid)
		begin
			o_block       <= next_block;
			o_block_class <= next_class;
		end
	end

endmodule

// File: hdl/pcs_tx_fsm.sv
// Transmit state machine, judged from the current class and state only.
// No lookahead on the next block type.
// Strobes are combinational, one cycle ahead of the registered block.
module pcs_tx_fsm
	import pcs_pkg::*;
(
	input  logic         i_clock,
	input  logic         i_reset,
	input  coded_block_u i_block,
	input  block_class_e i_block_class,
	input  logic         i_block_valid,
	output coded_block_u o_block,
	output logic         o_block_valid,
	output logic         o_frame_strobe,
	output logic         o_error_strobe
);

	localparam logic [2:0] ST_INIT = 3'd0;
	localparam logic [2:0] ST_C    = 3'd1;
	localparam logic [2:0] ST_D    = 3'd2;
	localparam logic [2:0] ST_T    = 3'd3;
	localparam logic [2:0] ST_E    = 3'd4;

	logic [2:0]   state;
	logic [2:0]   next_state;
	coded_block_u error_block;

	// substituted on any illegal sequence
	always_comb
	begin
		error_block.ctrl_view.sync  = SYNC_CTRL;
		error_block.ctrl_view.btype = BTYPE_CTRL;
		error_block.ctrl_view.body  = {8{PCS_ERROR}};
	end

	always_comb
	begin
		next_state = ST_E;
		case (state)
			ST_D:
			begin
				if (i_block_class == CLASS_D)
					next_state = ST_D;
				else if (i_block_class == CLASS_T)
					next_state = ST_T;
			end
			ST_E:
			begin
				// recover on any recognized class
				case (i_block_class)
					CLASS_D, CLASS_S: next_state = ST_D;
					CLASS_T:          next_state = ST_T;
					CLASS_C:          next_state = ST_C;
					default:          next_state = ST_E;
				endcase
			end
			default:
			begin
				// init, C and T behave alike
				if (i_block_class == CLASS_C)
					next_state = ST_C;
				else if (i_block_class == CLASS_S)
					next_state = ST_D;
			end
		endcase
	end

	assign o_frame_strobe = i_block_valid && (next_state == ST_T);
	assign o_error_strobe = i_block_valid && (next_state == ST_E);

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			state         <= ST_INIT;
			o_block_valid <= 1'b0;
		end
		else
		begin
			o_block_valid <= i_block_valid;
			if (i_block_valid)
				state <= next_state;
		end
	end

	always_ff @(posedge i_clock)
	begin
		if (i_block_valid)
			o_block <= (next_state == ST_E) ? error_block : i_block;
	end

endmodule

// File: hdl/pcs_tx_stats.sv
// Frame and error block counters.
// Both saturate at all ones and never wrap.
module pcs_tx_stats
#(
	parameter int COUNT_WIDTH = 16
)
(
	input  logic                   i_clock,
	input  logic                   i_reset,
	input  logic                   i_frame_strobe,
	input  logic                   i_error_strobe,
	output logic [COUNT_WIDTH-1:0] o_frame_count,
	output logic [COUNT_WIDTH-1:0] o_error_count
);

	////////////////////////////////////////
	// one terminate block per frame
	always_ff @(posedge i_clock)
	begin
		if (i_reset)
			o_frame_count <= '0;
		else if (i_frame_strobe && (o_frame_count != '1))
			o_frame_count <= o_frame_count + 1'b1;
	end

	////////////////////////////////////////
	// error blocks, both encoded and substituted
	always_ff @(posedge i_clock)
	begin
		if (i_reset)
			o_error_count <= '0;
		else if (i_error_strobe && (o_error_count != '1))
			o_error_count <= o_error_count + 1'b1;
	end

endmodule

// File: hdl/pcs_tx_top.sv
// 10GBASE-R transmit PCS, CGMII word in, scrambled 66-bit block out.
// o_tx_valid follows i_enable by exactly 4 cycles, no back-pressure.
// Counts update one cycle before the matching o_tx_valid.
module pcs_tx_top
	import pcs_pkg::*;
#(
	parameter int COUNT_WIDTH = 16
)
(
	input  logic                   i_clock,
	input  logic                   i_reset,
	input  logic                   i_enable,
	input  logic [DATA_WIDTH-1:0]  i_tx_data,
	input  logic [CTRL_WIDTH-1:0]  i_tx_ctrl,
	output logic [BLOCK_WIDTH-1:0] o_tx_block,
	output logic                   o_tx_valid,
	output logic [COUNT_WIDTH-1:0] o_frame_count,
	output logic [COUNT_WIDTH-1:0] o_error_count
);

	// encoder to fsm
	coded_block_u enc_block;
	block_class_e enc_class;
	logic         enc_valid;
	// fsm to scrambler and stats
	coded_block_u fsm_block;
	logic         fsm_valid;
	logic         frame_strobe;
	logic         error_strobe;

	pcs_tx_encoder pcs_tx_encoder_inst (
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.i_enable      (i_enable),
		.i_tx_data     (i_tx_data),
		.i_tx_ctrl     (i_tx_ctrl),
		.o_block       (enc_block),
		.o_block_class (enc_class),
		.o_block_valid (enc_valid)
	);

	pcs_tx_fsm pcs_tx_fsm_inst (
		.i_clock        (i_clock),
		.i_reset        (i_reset),
		.i_block        (enc_block),
		.i_block_class  (enc_class),
		.i_block_valid  (enc_valid),
		.o_block        (fsm_block),
		.o_block_valid  (fsm_valid),
		.o_frame_strobe (frame_strobe),
		.o_error_strobe (error_strobe)
	);

	pcs_scrambler pcs_scrambler_inst (
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.i_block       (fsm_block),
		.i_block_valid (fsm_valid),
		.o_block       (o_tx_block),
		.o_block_valid (o_tx_valid)
	);

	pcs_tx_stats #(
		.COUNT_WIDTH (COUNT_WIDTH)
	) pcs_tx_stats_inst (
		.i_clock        (i_clock),
		.i_reset        (i_reset),
		.i_frame_strobe (frame_strobe),
		.i_error_strobe (error_strobe),
		.o_frame_count  (o_frame_count),
		.o_error_count  (o_error_count)
	);

endmodule

// File: tb.f
hdl/pcs_pkg.sv
hdl/pcs_tx_encoder.sv
hdl/pcs_tx_fsm.sv
hdl/pcs_scrambler.sv
hdl/pcs_tx_stats.sv
hdl/pcs_tx_top.sv
test/pcs_tx_assertions.sv
test/pcs_tx_tb.sv

// File: test/pcs_tx_assertions.sv
// Concurrent checks on the transmit top level, bound from the testbench.
// Latency check assumes no reset between a strobe and its block.
module pcs_tx_assertions
#(
	parameter int COUNT_WIDTH = 16
)
(
	input logic                   i_clock,
	input logic                   i_reset,
	input logic                   i_enable,
	input logic [65:0]            o_tx_block,
	input logic                   o_tx_valid,
	input logic [COUNT_WIDTH-1:0] o_frame_count,
	input logic [COUNT_WIDTH-1:0] o_error_count
);
	timeunit 1ns;
	timeprecision 1ps;

	// every strobe gives a block 4 cycles later
	a_latency: assert property (@(posedge i_clock) disable iff (i_reset)
		i_enable |-> ##4 o_tx_valid)
		else $error("block missing 4 cycles after strobe");

	// and no block without a strobe
	a_no_extra: assert property (@(posedge i_clock) disable iff (i_reset)
		o_tx_valid |-> $past(i_enable, 4))
		else $error("block without matching strobe");

	a_sync: assert property (@(posedge i_clock) disable iff (i_reset)
		o_tx_valid |-> (o_tx_block[65:64] == 2'b01 || o_tx_block[65:64] == 2'b10))
		else $error("invalid sync header");

	// saturating counters only go up
	a_frame_up: assert property (@(posedge i_clock) disable iff (i_reset)
		o_frame_count >= $past(o_frame_count))
		else $error("frame count decreased");

	a_error_up: assert property (@(posedge i_clock) disable iff (i_reset)
		o_error_count >= $past(o_error_count))
		else $error("error count decreased");

endmodule

// File: test/pcs_tx_input.txt
# gap ctrl data expected_unscrambled_block frame_count error_count
# gap in idle cycles, ctrl and data in hex, 66-bit block as {sync, payload} in hex
0 FF 0707070707070707 21E00000000000000 0 0
0 80 FB55555555555555 27855555555555555 0 0
0 00 0011223344556677 10011223344556677 0 0
1 FF FD07070707070707 28700000000000000 1 0
0 80 FBD5D5D5D5D5D5D5 278D5D5D5D5D5D5D5 1 0
0 7F AAFD070707070707 299AA000000000000 2 0
2 80 FB55555555555555 27855555555555555 2 0
0 3F 1122FD0707070707 2AA11220000000000 3 0
0 80 FB55555555555555 27855555555555555 3 0
3 1F 112233FD07070707 2B411223300000000 4 0
0 80 FB55555555555555 27855555555555555 4 0
0 0F 11223344FD070707 2CC11223344000000 5 0
0 80 FB55555555555555 27855555555555555 5 0
0 07 1122334455FD0707 2D211223344550000 6 0
0 80 FB55555555555555 27855555555555555 6 0
0 03 112233445566FD07 2E111223344556600 7 0
0 80 FB55555555555555 27855555555555555 7 0
0 00 8899AABBCCDDEEFF 18899AABBCCDDEEFF 7 0
0 01 11223344556677FD 2FF11223344556677 8 0
1 80 9C00000100000000 24B00000100000000 8 0
0 80 5C12345600000000 24B123456F0000000 8 0
0 80 FB55555555555555 27855555555555555 8 0
0 0F 11223344FDFE07FE 2CC1122334407801E 9 0
0 80 FB55555555555555 27855555555555555 9 0
0 FF FDFE070707070707 28700780000000000 10 0
2 0F 1122334455667788 21E3C78F1E3C78F1E 10 1
0 FF 0707070707070707 21E00000000000000 10 1
0 00 0011223344556677 21E3C78F1E3C78F1E 10 2
0 FF 0707070707070707 21E00000000000000 10 2

// File: test/pcs_tx_tb.sv
// Testbench for the transmit PCS with stimulus and expectations from a text file.
// File blocks are unscrambled and outputs are descrambled here before the compare.
// Descrambler history starts all ones to match the scrambler reset value.
// Counts are taken one cycle before each block, when they cover exactly that block.
module pcs_tx_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int COUNT_WIDTH = 16;
	localparam int MAX_LINES   = 256;
	localparam int RESET_CYCLES = 16;

	logic                   i_clock;
	logic                   i_reset;
	logic                   i_enable;
	logic [63:0]            i_tx_data;
	logic [7:0]             i_tx_ctrl;
	logic [65:0]            o_tx_block;
	logic                   o_tx_valid;
	logic [COUNT_WIDTH-1:0] o_frame_count;
	logic [COUNT_WIDTH-1:0] o_error_count;

	// test vectors
	int          gap_tab [MAX_LINES];
	logic [7:0]  ctrl_tab [MAX_LINES];
	logic [63:0] data_tab [MAX_LINES];
	logic [65:0] block_tab [MAX_LINES];
	int          frame_tab [MAX_LINES];
	int          error_tab [MAX_LINES];
	int          line_count;
	bit          lines_loaded;

	int mismatch_count;
	int other_count;
	int received;

	pcs_tx_top #(
		.COUNT_WIDTH (COUNT_WIDTH)
	) pcs_tx_top_inst (
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.i_enable      (i_enable),
		.i_tx_data     (i_tx_data),
		.i_tx_ctrl     (i_tx_ctrl),
		.o_tx_block    (o_tx_block),
		.o_tx_valid    (o_tx_valid),
		.o_frame_count (o_frame_count),
		.o_error_count (o_error_count)
	);

	bind pcs_tx_top pcs_tx_assertions #(.COUNT_WIDTH(COUNT_WIDTH)) pcs_tx_assertions_inst (.*);

	initial
	begin
		i_clock = 1'b0;
		forever
			#20 i_clock = ~i_clock;
	end

	////////////////////////////////////////
	// vector file with # comment lines
	task automatic load_vectors();
		int    fd;
		int    n;
		string line;
		fd = $fopen("test/pcs_tx_input.txt", "r");
		line_count = 0;
		if (fd == 0)
		begin
			$display("cannot open test/pcs_tx_input.txt");
			other_count++;
		end
		else
		begin
			while (!$feof(fd) && line_count < MAX_LINES)
			begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() > 0 && line[0] != "#")
				begin
					n = $sscanf(line, "%d %h %h %h %d %d", gap_tab[line_count],
						ctrl_tab[line_count], data_tab[line_count], block_tab[line_count],
						frame_tab[line_count], error_tab[line_count]);
					if (n == 6)
						line_count++;
				end
			end
			$fclose(fd);
		end
		lines_loaded = 1'b1;
	endtask

	// undo x^58 + x^39 + 1 with the received scrambled bits as history
	function automatic logic [63:0] descramble(input logic [63:0] rx,
		inout logic [57:0] hist);
		logic [63:0] plain;
		for (int i = 0; i < 64; i++)
		begin
			plain[i] = rx[i] ^ hist[38] ^ hist[57];
			hist = {hist[56:0], rx[i]};
		end
		return plain;
	endfunction

	////////////////////////////////////////
	// driver and end of run
	initial
	begin
		int extra;
		lines_loaded   = 1'b0;
		mismatch_count = 0;
		other_count    = 0;
		i_reset   = 1'b1;
		i_enable  = 1'b0;
		i_tx_data = '0;
		i_tx_ctrl = '0;
		void'($urandom(79));
		load_vectors();
		repeat (RESET_CYCLES) @(posedge i_clock);
		@(negedge i_clock);
		i_reset = 1'b0;
		// quiet outputs before the first strobe
		repeat (3)
		begin
			@(negedge i_clock);
			if (o_tx_valid !== 1'b0 || o_frame_count !== '0 || o_error_count !== '0)
			begin
				$display("outputs not idle after reset at %0t ns", $time);
				other_count++;
			end
		end
		for (int k = 0; k < line_count; k++)
		begin
			extra = $urandom % 3;
			repeat (gap_tab[k] + extra) @(negedge i_clock);
			i_enable  = 1'b1;
			i_tx_ctrl = ctrl_tab[k];
			i_tx_data = data_tab[k];
			@(negedge i_clock);
			i_enable  = 1'b0;
			i_tx_ctrl = '0;
			i_tx_data = '0;
		end
		wait (received >= line_count);
		repeat (6) @(negedge i_clock);
		$display("errors: %0d mismatches, %0d other", mismatch_count, other_count);
		if (mismatch_count == 0 && other_count == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

	////////////////////////////////////////
	// monitor sampling on the falling edge
	initial
	begin
		logic [57:0]            hist;
		logic [63:0]            plain;
		logic [COUNT_WIDTH-1:0] prev_frame;
		logic [COUNT_WIDTH-1:0] prev_error;
		received = 0;
		hist = '1;
		prev_frame = '0;
		prev_error = '0;
		forever
		begin
			@(negedge i_clock);
			if (!i_reset && o_tx_valid)
			begin
				if (received >= line_count)
				begin
					$display("unexpected extra block at %0t ns", $time);
					other_count++;
				end
				else
				begin
					plain = descramble(o_tx_block[63:0], hist);
					if (o_tx_block[65:64] != block_tab[received][65:64])
					begin
						$display("Mismatch at %0t ns: o_tx_block sync got %b expected %b",
							$time, o_tx_block[65:64], block_tab[received][65:64]);
						mismatch_count++;
					end
					if (plain != block_tab[received][63:0])
					begin
						$display("Mismatch at %0t ns: o_tx_block payload got %h expected %h",
							$time, plain, block_tab[received][63:0]);
						mismatch_count++;
					end
					// a back to back strobe may already count in this cycle
					if (prev_frame != frame_tab[received])
					begin
						$display("Mismatch at %0t ns: o_frame_count got %0d expected %0d",
							$time, prev_frame, frame_tab[received]);
						mismatch_count++;
					end
					if (prev_error != error_tab[received])
					begin
						$display("Mismatch at %0t ns: o_error_count got %0d expected %0d",
							$time, prev_error, error_tab[received]);
						mismatch_count++;
					end
				end
				received++;
			end
			// counts as of the cycle before the next sample
			prev_frame = o_frame_count;
			prev_error = o_error_count;
		end
	end

	// watchdog allows ten cycles per vector after reset
	initial
	begin
		wait (lines_loaded);
		#((RESET_CYCLES + line_count * 10) * 40);
		$display("timeout, only %0d of %0d blocks seen", received, line_count);
		other_count++;
		$display("errors: %0d mismatches, %0d other", mismatch_count, other_count);
		$display("TB FAILED");
		$finish;
	end

endmodule
